// File: src/cpu_pkg.sv
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [4:0]  reg_addr_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_LUI
	} alu_op_t;

	// primary opcodes, instr[31:26]
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_J       = 6'h02;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_LUI     = 6'h0f;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_SW      = 6'h2b;

	// SPECIAL function field, instr[5:0]
	localparam logic [5:0] FN_SLL  = 6'h00;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_SLT  = 6'h2a;

endpackage

// File: src/regfile.sv
`timescale 1ns/100ps

module regfile (
	input  logic              clk,
	input  logic              rst,
	input  cpu_pkg::reg_addr_t raddr_a,
	input  cpu_pkg::reg_addr_t raddr_b,
	output cpu_pkg::word_t     rdata_a,
	output cpu_pkg::word_t     rdata_b,
	input  logic              we,
	input  cpu_pkg::reg_addr_t waddr,
	input  cpu_pkg::word_t     wdata
);

	import cpu_pkg::*;

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	// entry zero is never written, so it reads back as zero
	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];

endmodule

// File: src/instr_fetch.sv
`timescale 1ns/100ps

module instr_fetch #(
	parameter cpu_pkg::addr_t RESET_PC = 32'hbfc0_0000
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           stall_if,
	input  logic           flush_id,
	input  logic           branch_taken,
	input  cpu_pkg::addr_t branch_target,
	input  cpu_pkg::word_t ibus_rddata,
	input  logic           ibus_stall,
	output logic           ibus_read,
	output cpu_pkg::addr_t ibus_addr,
	output logic           if_valid,
	output cpu_pkg::addr_t if_pc,
	output cpu_pkg::word_t if_instr
);

	import cpu_pkg::*;

	addr_t pc;
	logic  fetch_en;
	logic  redir;
	addr_t redir_pc;
	logic  fetch_done;

	assign ibus_read  = fetch_en;
	assign ibus_addr  = pc;
	assign fetch_done = fetch_en && !ibus_stall;

	// pc and a pending redirect, kept while the bus holds the address
	always_ff @(posedge clk) begin
		if (rst) begin
			pc       <= RESET_PC;
			fetch_en <= 1'b0;
			redir    <= 1'b0;
		end else begin
			fetch_en <= 1'b1;
			if (!stall_if) begin
				if (branch_taken) begin
					if (fetch_done || !fetch_en) begin
						pc    <= branch_target;
						redir <= 1'b0;
					end else begin
						redir <= 1'b1;
					end
				end else if (fetch_done) begin
					pc    <= redir ? redir_pc : pc + 32'd4;
					redir <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_if && branch_taken) begin
			redir_pc <= branch_target;
		end
	end

	// fetch register, a bubble when the bus is stalled
	always_ff @(posedge clk) begin
		if (rst || flush_id) begin
			if_valid <= 1'b0;
		end else if (!stall_if) begin
			if_valid <= fetch_done && !redir;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_if) begin
			if_pc    <= pc;
			if_instr <= ibus_rddata;
		end
	end

endmodule

// File: src/decode_issue.sv
`timescale 1ns/100ps

module decode_issue (
	input  logic               clk,
	input  logic               rst,
	input  logic               stall_id,
	input  logic               flush_id,
	input  logic               stall_ex,
	input  logic               if_valid,
	input  cpu_pkg::addr_t     if_pc,
	input  cpu_pkg::word_t     if_instr,
	output cpu_pkg::reg_addr_t rs_addr,
	output cpu_pkg::reg_addr_t rt_addr,
	input  cpu_pkg::word_t     rs_data,
	input  cpu_pkg::word_t     rt_data,
	input  logic               ex_valid,
	input  cpu_pkg::reg_addr_t ex_rd,
	input  cpu_pkg::word_t     ex_result,
	input  logic               ex_is_load,
	input  logic               mem_valid,
	input  cpu_pkg::reg_addr_t mem_rd,
	input  cpu_pkg::word_t     mem_result,
	input  logic               wb_we,
	input  cpu_pkg::reg_addr_t wb_rd,
	input  cpu_pkg::word_t     wb_data,
	output logic               load_use,
	output logic               id_valid,
	output cpu_pkg::addr_t     id_pc,
	output cpu_pkg::alu_op_t   id_alu_op,
	output cpu_pkg::word_t     id_op_a,
	output cpu_pkg::word_t     id_op_b,
	output cpu_pkg::word_t     id_store_data,
	output cpu_pkg::word_t     id_imm,
	output cpu_pkg::reg_addr_t id_rd,
	output logic               id_is_load,
	output logic               id_is_store,
	output logic               id_is_beq,
	output logic               id_is_bne,
	output logic               id_is_jump,
	output cpu_pkg::addr_t     id_jump_target
);

	import cpu_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	word_t      imm_sext;
	word_t      rs_val;
	word_t      rt_val;
	alu_op_t    d_alu_op;
	word_t      d_op_a;
	word_t      d_op_b;
	reg_addr_t  d_rd;
	logic       uses_rs;
	logic       uses_rt;

	// youngest producer first
	function automatic word_t fwd(input reg_addr_t a, input word_t rf);
		word_t v;
		v = rf;
		if (a == 5'd0) begin
			v = '0;
		end else if (ex_valid && !ex_is_load && ex_rd == a) begin
			v = ex_result;
		end else if (mem_valid && mem_rd == a) begin
			v = mem_result;
		end else if (wb_we && wb_rd == a) begin
			v = wb_data;
		end
		return v;
	endfunction

	assign opcode   = if_instr[31:26];
	assign funct    = if_instr[5:0];
	assign rs_addr  = if_instr[25:21];
	assign rt_addr  = if_instr[20:16];
	assign imm_sext = {{16{if_instr[15]}}, if_instr[15:0]};

	always_comb begin
		rs_val = fwd(rs_addr, rs_data);
		rt_val = fwd(rt_addr, rt_data);
	end

	always_comb begin
		d_alu_op = ALU_ADD;
		d_op_a   = rs_val;
		d_op_b   = rt_val;
		d_rd     = '0;
		uses_rs  = 1'b1;
		uses_rt  = 1'b0;
		case (opcode)
			OP_SPECIAL: begin
				d_rd    = if_instr[15:11];
				uses_rt = 1'b1;
				case (funct)
					FN_ADDU: d_alu_op = ALU_ADD;
					FN_SUBU: d_alu_op = ALU_SUB;
					FN_AND:  d_alu_op = ALU_AND;
					FN_OR:   d_alu_op = ALU_OR;
					FN_XOR:  d_alu_op = ALU_XOR;
					FN_SLT:  d_alu_op = ALU_SLT;
					FN_SLL: begin
						d_alu_op = ALU_SLL;
						d_op_a   = rt_val;
						d_op_b   = {27'd0, if_instr[10:6]};
						uses_rs  = 1'b0;
					end
					// unknown function codes retire as nops
					default: d_rd = '0;
				endcase
			end
			OP_ADDIU: begin
				d_rd   = rt_addr;
				d_op_b = imm_sext;
			end
			OP_ORI: begin
				d_alu_op = ALU_OR;
				d_rd     = rt_addr;
				d_op_b   = {16'd0, if_instr[15:0]};
			end
			OP_LUI: begin
				d_alu_op = ALU_LUI;
				d_rd     = rt_addr;
				d_op_b   = {if_instr[15:0], 16'd0};
				uses_rs  = 1'b0;
			end
			OP_LW: d_rd = rt_addr;
			OP_SW, OP_BEQ, OP_BNE: uses_rt = 1'b1;
			default: uses_rs = 1'b0;
		endcase
	end

	// the producer in execute has no result yet
	assign load_use = if_valid && id_valid && id_rd != 5'd0 &&
		((uses_rs && id_rd == rs_addr) || (uses_rt && id_rd == rt_addr));

	always_ff @(posedge clk) begin
		if (rst || flush_id || (stall_id && !stall_ex)) begin
			id_valid <= 1'b0;
		end else if (!stall_id) begin
			id_valid <= if_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_id) begin
			id_pc          <= if_pc;
			id_alu_op      <= d_alu_op;
			id_op_a        <= d_op_a;
			id_op_b        <= d_op_b;
			id_store_data  <= rt_val;
			id_imm         <= imm_sext;
			id_rd          <= d_rd;
			id_is_load     <= opcode == OP_LW;
			id_is_store    <= opcode == OP_SW;
			id_is_beq      <= opcode == OP_BEQ;
			id_is_bne      <= opcode == OP_BNE;
			id_is_jump     <= opcode == OP_J;
			id_jump_target <= {4'd0, if_instr[25:0], 2'b00};
		end
	end

endmodule

// File: src/instr_exec.sv
`timescale 1ns/100ps

module instr_exec (
	input  logic               clk,
	input  logic               rst,
	input  logic               stall_ex,
	input  logic               id_valid,
	input  cpu_pkg::addr_t     id_pc,
	input  cpu_pkg::alu_op_t   id_alu_op,
	input  cpu_pkg::word_t     id_op_a,
	input  cpu_pkg::word_t     id_op_b,
	input  cpu_pkg::word_t     id_store_data,
	input  cpu_pkg::word_t     id_imm,
	input  cpu_pkg::reg_addr_t id_rd,
	input  logic               id_is_load,
	input  logic               id_is_store,
	input  logic               id_is_beq,
	input  logic               id_is_bne,
	input  logic               id_is_jump,
	input  cpu_pkg::addr_t     id_jump_target,
	output logic               branch_taken,
	output cpu_pkg::addr_t     branch_target,
	output logic               ex_valid,
	output cpu_pkg::reg_addr_t ex_rd,
	output cpu_pkg::word_t     ex_result,
	output logic               ex_is_load,
	output logic               ex_is_store,
	output cpu_pkg::word_t     ex_store_data
);

	import cpu_pkg::*;

	word_t alu_out;
	word_t result;
	addr_t pc_plus4;
	logic  equal;

	always_comb begin
		case (id_alu_op)
			ALU_ADD: alu_out = id_op_a + id_op_b;
			ALU_SUB: alu_out = id_op_a - id_op_b;
			ALU_AND: alu_out = id_op_a & id_op_b;
			ALU_OR:  alu_out = id_op_a | id_op_b;
			ALU_XOR: alu_out = id_op_a ^ id_op_b;
			ALU_SLT: alu_out = {31'd0, $signed(id_op_a) < $signed(id_op_b)};
			ALU_SLL: alu_out = id_op_a << id_op_b[4:0];
			default: alu_out = id_op_b;
		endcase
	end

	// effective address for lw and sw
	assign result = (id_is_load || id_is_store) ? id_op_a + id_imm : alu_out;

	assign pc_plus4 = id_pc + 32'd4;
	assign equal    = id_op_a == id_op_b;

	assign branch_taken = id_valid &&
		((id_is_beq && equal) || (id_is_bne && !equal) || id_is_jump);
	assign branch_target = id_is_jump ? {pc_plus4[31:28], id_jump_target[27:0]}
		: pc_plus4 + {id_imm[29:0], 2'b00};

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid <= 1'b0;
		end else if (!stall_ex) begin
			ex_valid <= id_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_ex) begin
			ex_rd         <= id_rd;
			ex_result     <= result;
			ex_is_load    <= id_is_load;
			ex_is_store   <= id_is_store;
			ex_store_data <= id_store_data;
		end
	end

endmodule

// File: src/instr_mem.sv
`timescale 1ns/100ps

module instr_mem (
	input  logic               clk,
	input  logic               rst,
	input  logic               ex_valid,
	input  cpu_pkg::reg_addr_t ex_rd,
	input  cpu_pkg::word_t     ex_result,
	input  logic               ex_is_load,
	input  logic               ex_is_store,
	input  cpu_pkg::word_t     ex_store_data,
	input  cpu_pkg::word_t     dbus_rddata,
	input  logic               dbus_stall,
	output logic               dbus_read,
	output logic               dbus_write,
	output cpu_pkg::addr_t     dbus_addr,
	output cpu_pkg::word_t     dbus_wdata,
	output logic               mem_busy,
	output logic               mem_valid,
	output cpu_pkg::reg_addr_t mem_rd,
	output cpu_pkg::word_t     mem_result,
	output logic               wb_we,
	output cpu_pkg::reg_addr_t wb_rd,
	output cpu_pkg::word_t     wb_data
);

	import cpu_pkg::*;

	assign dbus_read  = ex_valid && ex_is_load;
	assign dbus_write = ex_valid && ex_is_store;
	assign dbus_addr  = ex_result;
	assign dbus_wdata = ex_store_data;
	assign mem_busy   = (dbus_read || dbus_write) && dbus_stall;

	// load data is only meaningful in the handshake cycle
	assign mem_valid  = ex_valid && !mem_busy;
	assign mem_rd     = ex_rd;
	assign mem_result = ex_is_load ? dbus_rddata : ex_result;

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_we <= 1'b0;
		end else if (!mem_busy) begin
			wb_we <= ex_valid && ex_rd != 5'd0;
		end
	end

	always_ff @(posedge clk) begin
		if (!mem_busy) begin
			wb_rd   <= ex_rd;
			wb_data <= mem_result;
		end
	end

endmodule

// File: src/pipe_ctrl.sv
`timescale 1ns/100ps

module pipe_ctrl (
	input  logic load_use,
	input  logic branch_taken,
	input  logic mem_busy,
	output logic stall_if,
	output logic stall_id,
	output logic flush_id,
	output logic stall_ex
);

	logic hold_front;

	// a stalled data access freezes the whole pipe
	assign stall_ex = mem_busy;

	// a taken branch wins over load-use, the dependent instruction is squashed
	assign flush_id = branch_taken && !mem_busy;

	assign hold_front = load_use && !branch_taken;

	// instruction bus stalls are absorbed inside fetch as bubbles
	assign stall_id = mem_busy || hold_front;
	assign stall_if = mem_busy || hold_front;

endmodule

// File: src/cpu_core.sv
`timescale 1ns/100ps

module cpu_core #(
	parameter cpu_pkg::addr_t RESET_PC = 32'hbfc0_0000
) (
	input  logic           clk,
	input  logic           rst,
	output logic           ibus_read,
	output cpu_pkg::addr_t ibus_addr,
	input  cpu_pkg::word_t ibus_rddata,
	input  logic           ibus_stall,
	output logic           dbus_read,
	output logic           dbus_write,
	output cpu_pkg::addr_t dbus_addr,
	output cpu_pkg::word_t dbus_wdata,
	input  cpu_pkg::word_t dbus_rddata,
	input  logic           dbus_stall
);

	import cpu_pkg::*;

	logic      stall_if, stall_id, flush_id, stall_ex;
	logic      load_use, mem_busy;
	logic      branch_taken;
	addr_t     branch_target;
	logic      if_valid;
	addr_t     if_pc;
	word_t     if_instr;
	reg_addr_t rs_addr, rt_addr;
	word_t     rs_data, rt_data;
	logic      id_valid, id_is_load, id_is_store, id_is_beq, id_is_bne, id_is_jump;
	addr_t     id_pc, id_jump_target;
	alu_op_t   id_alu_op;
	word_t     id_op_a, id_op_b, id_store_data, id_imm;
	reg_addr_t id_rd;
	logic      ex_valid, ex_is_load, ex_is_store;
	reg_addr_t ex_rd;
	word_t     ex_result, ex_store_data;
	logic      mem_valid, wb_we;
	reg_addr_t mem_rd, wb_rd;
	word_t     mem_result, wb_data;

	instr_fetch #(
		.RESET_PC ( RESET_PC )
	) instr_fetch_i (
		.clk, .rst, .stall_if, .flush_id, .branch_taken, .branch_target,
		.ibus_rddata, .ibus_stall, .ibus_read, .ibus_addr,
		.if_valid, .if_pc, .if_instr
	);

	decode_issue decode_issue_i (
		.clk, .rst, .stall_id, .flush_id, .stall_ex,
		.if_valid, .if_pc, .if_instr,
		.rs_addr, .rt_addr, .rs_data, .rt_data,
		.ex_valid, .ex_rd, .ex_result, .ex_is_load,
		.mem_valid, .mem_rd, .mem_result, .wb_we, .wb_rd, .wb_data,
		.load_use, .id_valid, .id_pc, .id_alu_op, .id_op_a, .id_op_b,
		.id_store_data, .id_imm, .id_rd, .id_is_load, .id_is_store,
		.id_is_beq, .id_is_bne, .id_is_jump, .id_jump_target
	);

	regfile regfile_i (
		.clk,
		.rst,
		.raddr_a ( rs_addr ),
		.raddr_b ( rt_addr ),
		.rdata_a ( rs_data ),
		.rdata_b ( rt_data ),
		.we      ( wb_we   ),
		.waddr   ( wb_rd   ),
		.wdata   ( wb_data )
	);

	instr_exec instr_exec_i (
		.clk, .rst, .stall_ex,
		.id_valid, .id_pc, .id_alu_op, .id_op_a, .id_op_b, .id_store_data,
		.id_imm, .id_rd, .id_is_load, .id_is_store, .id_is_beq, .id_is_bne,
		.id_is_jump, .id_jump_target,
		.branch_taken, .branch_target,
		.ex_valid, .ex_rd, .ex_result, .ex_is_load, .ex_is_store, .ex_store_data
	);

	instr_mem instr_mem_i (
		.clk, .rst,
		.ex_valid, .ex_rd, .ex_result, .ex_is_load, .ex_is_store, .ex_store_data,
		.dbus_rddata, .dbus_stall, .dbus_read, .dbus_write, .dbus_addr, .dbus_wdata,
		.mem_busy, .mem_valid, .mem_rd, .mem_result, .wb_we, .wb_rd, .wb_data
	);

	pipe_ctrl pipe_ctrl_i (
		.load_use, .branch_taken, .mem_busy,
		.stall_if, .stall_id, .flush_id, .stall_ex
	);

endmodule

// File: sim/core_props.sv
`timescale 1ns/100ps

module core_props (
	input logic           clk,
	input logic           rst,
	input logic           ibus_read,
	input cpu_pkg::addr_t ibus_addr,
	input logic           ibus_stall,
	input logic           dbus_read,
	input logic           dbus_write,
	input cpu_pkg::addr_t dbus_addr,
	input cpu_pkg::word_t dbus_wdata,
	input logic           dbus_stall,
	input logic           stall_id,
	input logic           flush_id,
	input logic           stall_ex
);

	// fetch address frozen until the bus lets it through
	ibus_hold: assert property (@(posedge clk) disable iff (rst)
		ibus_read && ibus_stall |=> ibus_read && $stable(ibus_addr))
		else $error("ibus_addr moved while ibus_stall was high");

	dbus_hold: assert property (@(posedge clk) disable iff (rst)
		(dbus_read || dbus_write) && dbus_stall |=>
		$stable(dbus_read) && $stable(dbus_write) &&
		$stable(dbus_addr) && $stable(dbus_wdata))
		else $error("data bus request changed while dbus_stall was high");

	dbus_one_hot: assert property (@(posedge clk) disable iff (rst)
		!(dbus_read && dbus_write))
		else $error("dbus_read and dbus_write high together");

	// first reset edge still sees power-up values
	reset_quiet: assert property (@(posedge clk)
		rst && $past(rst) |-> !ibus_read && !dbus_read && !dbus_write)
		else $error("bus request active during reset");

	// a squashed instruction cannot branch
	flush_single: assert property (@(posedge clk) disable iff (rst)
		flush_id |=> !flush_id)
		else $error("flush_id high in two consecutive cycles");

	// the inserted bubble clears the hazard
	load_use_single: assert property (@(posedge clk) disable iff (rst)
		stall_id && !stall_ex |=> !stall_id || stall_ex)
		else $error("load-use hold lasted more than one cycle");

endmodule

bind cpu_core core_props core_props_i (
	.clk        ( clk        ),
	.rst        ( rst        ),
	.ibus_read  ( ibus_read  ),
	.ibus_addr  ( ibus_addr  ),
	.ibus_stall ( ibus_stall ),
	.dbus_read  ( dbus_read  ),
	.dbus_write ( dbus_write ),
	.dbus_addr  ( dbus_addr  ),
	.dbus_wdata ( dbus_wdata ),
	.dbus_stall ( dbus_stall ),
	.stall_id   ( stall_id   ),
	.flush_id   ( flush_id   ),
	.stall_ex   ( stall_ex   )
);

// File: sim/core_tb.sv
`timescale 1ns/100ps

module core_tb;

	import cpu_pkg::*;

	localparam addr_t     START_PC   = 32'h0040_0000;
	localparam addr_t     DATA_BASE  = 32'h0000_1000;
	localparam int        IMEM_WORDS = 512;
	localparam int        DMEM_WORDS = 512;
	localparam int        BODY_LEN   = 200;
	localparam int        TIMEOUT    = 20000;
	localparam reg_addr_t BASE_REG   = 5'd28;

	logic  clk;
	logic  rst;
	logic  ibus_read;
	addr_t ibus_addr;
	word_t ibus_rddata;
	logic  ibus_stall;
	logic  dbus_read;
	logic  dbus_write;
	addr_t dbus_addr;
	word_t dbus_wdata;
	word_t dbus_rddata;
	logic  dbus_stall;

	integer seed = 95;
	int     errors;
	int     stores_seen;
	int     loads_seen;
	int     exp_stores;
	int     prog_len;
	logic   first_fetch_seen;
	addr_t  final_pc;

	word_t imem [IMEM_WORDS];
	word_t dmem_init [DMEM_WORDS];
	word_t dmem [DMEM_WORDS];
	word_t m_regs [32];
	word_t m_mem [DMEM_WORDS];
	addr_t exp_st_addr [$];
	word_t exp_st_data [$];
	addr_t exp_ld_addr [$];

	cpu_core #(
		.RESET_PC ( START_PC )
	) cpu_core_i (
		.clk, .rst,
		.ibus_read, .ibus_addr, .ibus_rddata, .ibus_stall,
		.dbus_read, .dbus_write, .dbus_addr, .dbus_wdata, .dbus_rddata, .dbus_stall
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic int rand_below(input int n);
		int r;
		r = $random(seed);
		return (r & 32'h7fff_ffff) % n;
	endfunction

	function automatic reg_addr_t pick_reg(input int lo, input int n);
		int v;
		v = lo + rand_below(n);
		return v[4:0];
	endfunction

	function automatic word_t enc_r(input logic [5:0] fn, input reg_addr_t rs,
			input reg_addr_t rt, input reg_addr_t rd, input logic [4:0] sh);
		return {OP_SPECIAL, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t enc_i(input logic [5:0] op, input reg_addr_t rs,
			input reg_addr_t rt, input int imm);
		return {op, rs, rt, imm[15:0]};
	endfunction

	function automatic word_t enc_j(input addr_t target);
		return {OP_J, target[27:2]};
	endfunction

	function automatic addr_t pc_of(input int idx);
		return START_PC + 4 * idx;
	endfunction

	// -1 when outside the region or not word aligned
	function automatic int word_index(input addr_t a, input addr_t base, input int words);
		addr_t off;
		off = a - base;
		if (a[1:0] != 2'b00 || off >= 4 * words) begin
			return -1;
		end
		return int'(off >> 2);
	endfunction

	function automatic word_t instr_at(input addr_t a);
		int idx;
		idx = word_index(a, START_PC, IMEM_WORDS);
		if (idx < 0) begin
			return '0;
		end
		return imem[idx];
	endfunction

	task automatic emit(input word_t w);
		imem[prog_len] = w;
		prog_len++;
	endtask

	// forward-only control flow, never past the end of the body
	function automatic word_t random_instr(input int p, input int body_end);
		int         kind;
		int         off;
		reg_addr_t  rd;
		reg_addr_t  rs;
		reg_addr_t  rt;
		logic [4:0] sh;
		kind = rand_below(14);
		rd   = pick_reg(1, 12);
		rs   = pick_reg(0, 13);
		rt   = pick_reg(0, 13);
		sh   = pick_reg(0, 32);
		off  = rand_below(6) + 1;
		if (off > body_end - p - 1) begin
			off = body_end - p - 1;
		end
		case (kind)
			0: return enc_r(FN_ADDU, rs, rt, rd, 5'd0);
			1: return enc_r(FN_SUBU, rs, rt, rd, 5'd0);
			2: return enc_r(FN_AND, rs, rt, rd, 5'd0);
			3: return enc_r(FN_OR, rs, rt, rd, 5'd0);
			4: return enc_r(FN_XOR, rs, rt, rd, 5'd0);
			5: return enc_r(FN_SLT, rs, rt, rd, 5'd0);
			6: return enc_r(FN_SLL, 5'd0, rt, rd, sh);
			7: return enc_i(OP_ADDIU, rs, rd, $random(seed));
			8: return enc_i(OP_ORI, rs, rd, $random(seed));
			9: return enc_i(OP_LUI, 5'd0, rd, $random(seed));
			10: return enc_i(OP_LW, BASE_REG, rd, 4 * rand_below(256));
			11: return enc_i(OP_SW, BASE_REG, rt, 4 * rand_below(256));
			12: begin
				if (rand_below(2) == 0) begin
					return enc_i(OP_BNE, rs, rt, off);
				end
				// equal operands now and then so beq gets taken
				if (rand_below(2) == 0) begin
					rt = rs;
				end
				return enc_i(OP_BEQ, rs, rt, off);
			end
			default: return enc_j(pc_of(p + 1 + off));
		endcase
	endfunction

	task automatic build_program();
		word_t v;
		int    body_end;
		for (int i = 0; i < IMEM_WORDS; i++) begin
			// unused words spin on their own address
			imem[i] = enc_j(pc_of(i));
		end
		for (int i = 0; i < DMEM_WORDS; i++) begin
			dmem_init[i] = $random(seed);
			dmem[i]      = dmem_init[i];
		end
		prog_len = 0;
		for (int r = 1; r < 32; r++) begin
			v = (r[4:0] == BASE_REG) ? DATA_BASE : $random(seed);
			emit(enc_i(OP_LUI, 5'd0, r[4:0], v[31:16]));
			emit(enc_i(OP_ORI, r[4:0], r[4:0], v[15:0]));
		end
		body_end = prog_len + BODY_LEN;
		while (prog_len < body_end) begin
			emit(random_instr(prog_len, body_end));
		end
		// register dump just above the random data area
		for (int r = 1; r < 32; r++) begin
			emit(enc_i(OP_SW, 5'd0, r[4:0], int'(DATA_BASE) + 1024 + 4 * r));
		end
		final_pc = pc_of(prog_len);
		emit(enc_j(final_pc));
	endtask

	task automatic run_model();
		addr_t pc;
		addr_t next;
		addr_t ea;
		word_t ins;
		word_t a;
		word_t b;
		word_t imm;
		int    steps;
		for (int i = 0; i < 32; i++) begin
			m_regs[i] = '0;
		end
		for (int i = 0; i < DMEM_WORDS; i++) begin
			m_mem[i] = dmem_init[i];
		end
		pc    = START_PC;
		steps = 0;
		while (pc != final_pc && steps < 4 * IMEM_WORDS) begin
			ins  = instr_at(pc);
			a    = m_regs[ins[25:21]];
			b    = m_regs[ins[20:16]];
			imm  = {{16{ins[15]}}, ins[15:0]};
			ea   = a + imm;
			next = pc + 32'd4;
			case (ins[31:26])
				OP_SPECIAL: begin
					case (ins[5:0])
						FN_ADDU: m_regs[ins[15:11]] = a + b;
						FN_SUBU: m_regs[ins[15:11]] = a - b;
						FN_AND:  m_regs[ins[15:11]] = a & b;
						FN_OR:   m_regs[ins[15:11]] = a | b;
						FN_XOR:  m_regs[ins[15:11]] = a ^ b;
						FN_SLT:  m_regs[ins[15:11]] = {31'd0, $signed(a) < $signed(b)};
						FN_SLL:  m_regs[ins[15:11]] = b << ins[10:6];
						default: ;
					endcase
				end
				OP_ADDIU: m_regs[ins[20:16]] = a + imm;
				OP_ORI:   m_regs[ins[20:16]] = a | {16'd0, ins[15:0]};
				OP_LUI:   m_regs[ins[20:16]] = {ins[15:0], 16'd0};
				OP_LW: begin
					exp_ld_addr.push_back(ea);
					m_regs[ins[20:16]] = m_mem[word_index(ea, DATA_BASE, DMEM_WORDS)];
				end
				OP_SW: begin
					exp_st_addr.push_back(ea);
					exp_st_data.push_back(b);
					m_mem[word_index(ea, DATA_BASE, DMEM_WORDS)] = b;
				end
				OP_BEQ: begin
					if (a == b) begin
						next = next + (imm << 2);
					end
				end
				OP_BNE: begin
					if (a != b) begin
						next = next + (imm << 2);
					end
				end
				OP_J: next = {next[31:28], ins[25:0], 2'b00};
				default: ;
			endcase
			m_regs[0] = '0;
			pc        = next;
			steps++;
		end
		if (pc != final_pc) begin
			errors++;
			$display("reference model never reached the final self-jump");
		end
	endtask

	task automatic serve_ibus();
		if (ibus_read === 1'b1 && !first_fetch_seen) begin
			first_fetch_seen = 1'b1;
			assert (ibus_addr == START_PC) else begin
				errors++;
				$display("[FAIL] time %0t ibus_addr expected %h actual %h",
					$time, START_PC, ibus_addr);
			end
			assert (dbus_read === 1'b0 && dbus_write === 1'b0) else begin
				errors++;
				$display("data bus request active at the first fetch after reset");
			end
		end
		ibus_stall  = rand_below(10) < 3;
		ibus_rddata = instr_at(ibus_addr);
	endtask

	task automatic check_store(input int idx);
		stores_seen++;
		if (exp_st_addr.size() == 0) begin
			errors++;
			$display("unexpected store to %h at time %0t after the last expected one",
				dbus_addr, $time);
		end else begin
			assert (dbus_addr == exp_st_addr[0]) else begin
				errors++;
				$display("[FAIL] time %0t dbus_addr expected %h actual %h",
					$time, exp_st_addr[0], dbus_addr);
			end
			assert (dbus_wdata == exp_st_data[0]) else begin
				errors++;
				$display("[FAIL] time %0t dbus_wdata expected %h actual %h",
					$time, exp_st_data[0], dbus_wdata);
			end
			exp_st_addr.delete(0);
			exp_st_data.delete(0);
		end
		if (idx >= 0) begin
			dmem[idx] = dbus_wdata;
		end
	endtask

	task automatic check_load();
		loads_seen++;
		if (exp_ld_addr.size() == 0) begin
			errors++;
			$display("unexpected load from %h at time %0t", dbus_addr, $time);
		end else begin
			assert (dbus_addr == exp_ld_addr[0]) else begin
				errors++;
				$display("[FAIL] time %0t dbus_addr expected %h actual %h",
					$time, exp_ld_addr[0], dbus_addr);
			end
			exp_ld_addr.delete(0);
		end
	endtask

	// requests are stable here, an unstalled one completes at the next rising edge
	task automatic serve_dbus();
		int idx;
		dbus_stall  = rand_below(10) < 3;
		idx         = word_index(dbus_addr, DATA_BASE, DMEM_WORDS);
		dbus_rddata = (idx >= 0) ? dmem[idx] : '0;
		if (!dbus_stall && dbus_write === 1'b1) begin
			check_store(idx);
		end
		if (!dbus_stall && dbus_read === 1'b1) begin
			check_load();
		end
	endtask

	always @(negedge clk) begin
		serve_ibus();
		serve_dbus();
	end

	initial begin
		int cycles;
		rst              = 1'b1;
		ibus_rddata      = '0;
		ibus_stall       = 1'b0;
		dbus_rddata      = '0;
		dbus_stall       = 1'b0;
		errors           = 0;
		stores_seen      = 0;
		loads_seen       = 0;
		first_fetch_seen = 1'b0;
		build_program();
		run_model();
		exp_stores = exp_st_addr.size();
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		cycles = 0;
		while (stores_seen < exp_stores && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (stores_seen < exp_stores) begin
			errors++;
			$display("timeout: only %0d of %0d stores arrived within %0d cycles",
				stores_seen, exp_stores, TIMEOUT);
		end
		// room for a stray store to show up
		repeat (20) @(posedge clk);
		if (exp_ld_addr.size() != 0) begin
			errors++;
			$display("%0d expected loads never reached the data bus", exp_ld_addr.size());
		end
		$display("errors %0d, stores checked %0d, loads checked %0d",
			errors, stores_seen, loads_seen);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: all.f
src/cpu_pkg.sv
src/regfile.sv
src/instr_fetch.sv
src/decode_issue.sv
src/instr_exec.sv
src/instr_mem.sv
src/pipe_ctrl.sv
src/cpu_core.sv
sim/core_props.sv
sim/core_tb.sv
